// File: rtl/router_pkg.sv
package router_pkg;

  localparam int NUM_PORTS   = 5;
  localparam int NUM_VCS     = 2;
  localparam int NUM_NODES   = 16;
  localparam int BUF_DEPTH   = 4;
  localparam int CREDIT_INIT = 4;  // matches downstream fifo depth

  localparam int PORT_W    = 3;
  localparam int VC_W      = 1;
  localparam int NODE_W    = 4;
  localparam int CREDIT_W  = 3;
  localparam int PAYLOAD_W = 18;
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

  typedef logic [PORT_W-1:0]    port_id_t;
  typedef logic [VC_W-1:0]      vc_id_t;
  typedef logic [NODE_W-1:0]    node_id_t;
  typedef logic [CREDIT_W-1:0]  credit_cnt_t;
  typedef logic [PAYLOAD_W-1:0] payload_t;
  typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
  typedef logic [BUF_PTR_W:0]   buf_cnt_t;   // one extra bit so a full fifo counts BUF_DEPTH

  // same encoding as the legacy router flit type field
  typedef enum logic [1:0] {
    FLIT_BODY      = 2'd0,
    FLIT_TAIL      = 2'd1,
    FLIT_HEAD      = 2'd2,
    FLIT_HEAD_TAIL = 2'd3
  } flit_kind_e;

  typedef struct packed {
    flit_kind_e kind;
    vc_id_t     vc;
    node_id_t   src;
    node_id_t   dest;
    payload_t   payload;
  } flit_t;

  typedef struct packed {
    logic     wr_en;
    node_id_t node;
    port_id_t port;
    logic     valid;  // low removes the route for this node
  } route_cfg_t;

  typedef struct packed {
    logic     valid;
    port_id_t port;  // input port being forwarded
    vc_id_t   vc;
  } grant_t;

  typedef enum logic {
    ALLOC_FREE     = 1'b0,
    ALLOC_RESERVED = 1'b1
  } alloc_state_e;

endpackage

// File: rtl/route_table.sv
module route_table
  import router_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  route_cfg_t route_cfg,
  input  node_id_t   lookup_dest [NUM_PORTS],
  output port_id_t   lookup_port [NUM_PORTS],
  output logic       lookup_hit  [NUM_PORTS]
);

  logic     entry_valid [NUM_NODES];
  port_id_t entry_port  [NUM_NODES];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int n = 0; n < NUM_NODES; n++) begin
        entry_valid[n] <= 1'b0;
        entry_port[n]  <= '0;
      end
    end else if (route_cfg.wr_en) begin
      entry_valid[route_cfg.node] <= route_cfg.valid;
      entry_port[route_cfg.node]  <= route_cfg.port;
    end
  end

  // one read port per input, used on the arriving flit
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      lookup_port[p] = entry_port[lookup_dest[p]];
      lookup_hit[p]  = entry_valid[lookup_dest[p]];
    end
  end

endmodule

// File: rtl/vc_input_buffer.sv
module vc_input_buffer
  import router_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  flit_t              in_flit,
  input  logic               in_write,
  input  logic               route_hit,
  input  port_id_t           route_port,
  input  logic [NUM_VCS-1:0] dequeue,
  output flit_t              head_flit  [NUM_VCS],
  output logic               head_valid [NUM_VCS],
  output port_id_t           head_route [NUM_VCS],
  output logic [NUM_VCS-1:0] credit_out,
  output logic               empty
);

  flit_t    mem_flit  [NUM_VCS][BUF_DEPTH];
  port_id_t mem_route [NUM_VCS][BUF_DEPTH];  // output port resolved at arrival

  buf_ptr_t wr_ptr [NUM_VCS];
  buf_ptr_t rd_ptr [NUM_VCS];
  buf_cnt_t count  [NUM_VCS];

  logic [NUM_VCS-1:0] push;
  logic [NUM_VCS-1:0] full;

  always_comb begin
    for (int v = 0; v < NUM_VCS; v++) begin
      push[v] = in_write && route_hit && (in_flit.vc == vc_id_t'(v));  // unrouted flits dropped
      full[v] = (count[v] == buf_cnt_t'(BUF_DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    for (int v = 0; v < NUM_VCS; v++) begin
      if (push[v]) begin
        mem_flit[v][wr_ptr[v]]  <= in_flit;
        mem_route[v][wr_ptr[v]] <= route_port;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int v = 0; v < NUM_VCS; v++) begin
        wr_ptr[v] <= '0;
        rd_ptr[v] <= '0;
        count[v]  <= '0;
      end
      credit_out <= '0;
    end else begin
      for (int v = 0; v < NUM_VCS; v++) begin
        if (push[v]) begin
          wr_ptr[v] <= wr_ptr[v] + buf_ptr_t'(1);
        end
        if (dequeue[v]) begin
          rd_ptr[v] <= rd_ptr[v] + buf_ptr_t'(1);
        end
        count[v] <= count[v] + buf_cnt_t'(push[v]) - buf_cnt_t'(dequeue[v]);
      end
      credit_out <= dequeue;  // lands with the flit on the output link
    end
  end

  always_comb begin
    empty = 1'b1;
    for (int v = 0; v < NUM_VCS; v++) begin
      head_flit[v]  = mem_flit[v][rd_ptr[v]];
      head_route[v] = mem_route[v][rd_ptr[v]];
      head_valid[v] = (count[v] != '0);
      if (count[v] != '0) begin
        empty = 1'b0;
      end
    end
  end

  // upstream only sends while holding a credit for the channel
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    (in_write && route_hit) |-> !full[in_flit.vc]);

endmodule

// File: rtl/switch_allocator.sv
module switch_allocator
  import router_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  flit_t              head_flit  [NUM_PORTS][NUM_VCS],
  input  logic               head_valid [NUM_PORTS][NUM_VCS],
  input  port_id_t           head_route [NUM_PORTS][NUM_VCS],
  input  logic [NUM_VCS-1:0] credit_ok  [NUM_PORTS],
  output grant_t             grant      [NUM_PORTS],
  output logic [NUM_VCS-1:0] dequeue    [NUM_PORTS]
);

  // reservation per output port and vc
  alloc_state_e state [NUM_PORTS][NUM_VCS];
  port_id_t     owner [NUM_PORTS][NUM_VCS];

  flit_kind_e granted_kind [NUM_PORTS];

  always_comb begin
    logic req;
    logic is_head;
    logic eligible;
    for (int o = 0; o < NUM_PORTS; o++) begin
      grant[o]        = '0;
      granted_kind[o] = FLIT_BODY;
      // later hits override, so the highest vc and then the highest input wins
      for (int v = 0; v < NUM_VCS; v++) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
          req     = head_valid[i][v] && (head_route[i][v] == port_id_t'(o)) && credit_ok[o][v];
          is_head = (head_flit[i][v].kind == FLIT_HEAD) ||
                    (head_flit[i][v].kind == FLIT_HEAD_TAIL);
          if (state[o][v] == ALLOC_RESERVED) begin
            eligible = req && (owner[o][v] == port_id_t'(i));  // only the worm owner
          end else begin
            eligible = req && is_head;
          end
          if (eligible) begin
            grant[o].valid  = 1'b1;
            grant[o].port   = port_id_t'(i);
            grant[o].vc     = vc_id_t'(v);
            granted_kind[o] = head_flit[i][v].kind;
          end
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      dequeue[i] = '0;
      for (int v = 0; v < NUM_VCS; v++) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
          if (grant[o].valid && (grant[o].port == port_id_t'(i)) &&
              (grant[o].vc == vc_id_t'(v))) begin
            dequeue[i][v] = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        for (int v = 0; v < NUM_VCS; v++) begin
          state[o][v] <= ALLOC_FREE;
          owner[o][v] <= '0;
        end
      end
    end else begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (grant[o].valid) begin
          case (granted_kind[o])
            FLIT_HEAD: begin
              state[o][grant[o].vc] <= ALLOC_RESERVED;
              owner[o][grant[o].vc] <= grant[o].port;
            end
            FLIT_TAIL, FLIT_HEAD_TAIL: state[o][grant[o].vc] <= ALLOC_FREE;
            default: ;  // body keeps the reservation
          endcase
        end
      end
    end
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_check
    a_grant_has_credit: assert property (@(posedge clk) disable iff (reset)
      grant[o].valid |-> credit_ok[o][grant[o].vc]);

    for (genvar k = o + 1; k < NUM_PORTS; k++) begin : g_pair
      a_single_output: assert property (@(posedge clk) disable iff (reset)
        !(grant[o].valid && grant[k].valid &&
          (grant[o].port == grant[k].port) && (grant[o].vc == grant[k].vc)));
    end
  end

endmodule

// File: rtl/output_credit_port.sv
module output_credit_port
  import router_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  grant_t             grant,
  input  flit_t              granted_flit,
  input  logic [NUM_VCS-1:0] out_credit_in,
  output flit_t              out_flit,
  output logic               out_write,
  output logic [NUM_VCS-1:0] credit_ok
);

  credit_cnt_t credit [NUM_VCS];
  logic [NUM_VCS-1:0] take;

  always_comb begin
    for (int v = 0; v < NUM_VCS; v++) begin
      take[v]      = grant.valid && (grant.vc == vc_id_t'(v));
      credit_ok[v] = (credit[v] != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_write <= 1'b0;
      for (int v = 0; v < NUM_VCS; v++) begin
        credit[v] <= credit_cnt_t'(CREDIT_INIT);
      end
    end else begin
      out_write <= grant.valid;
      for (int v = 0; v < NUM_VCS; v++) begin
        // send and return in one cycle cancel out
        credit[v] <= credit[v] - credit_cnt_t'(take[v]) + credit_cnt_t'(out_credit_in[v]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant.valid) begin
      out_flit <= granted_flit;
    end
  end

  for (genvar v = 0; v < NUM_VCS; v++) begin : g_check
    // downstream never returns more credits than it was sent flits
    a_credit_max: assert property (@(posedge clk) disable iff (reset)
      credit[v] <= credit_cnt_t'(CREDIT_INIT));
  end

endmodule

// File: rtl/router_top.sv
module router_top
  import router_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  route_cfg_t         route_cfg,
  input  flit_t              in_flit       [NUM_PORTS],
  input  logic               in_write      [NUM_PORTS],
  output logic [NUM_VCS-1:0] in_credit     [NUM_PORTS],
  output flit_t              out_flit      [NUM_PORTS],
  output logic               out_write     [NUM_PORTS],
  input  logic [NUM_VCS-1:0] out_credit_in [NUM_PORTS],
  output logic               idle
);

  node_id_t           lookup_dest [NUM_PORTS];
  port_id_t           lookup_port [NUM_PORTS];
  logic               lookup_hit  [NUM_PORTS];
  flit_t              head_flit   [NUM_PORTS][NUM_VCS];
  logic               head_valid  [NUM_PORTS][NUM_VCS];
  port_id_t           head_route  [NUM_PORTS][NUM_VCS];
  logic [NUM_VCS-1:0] dequeue     [NUM_PORTS];
  logic [NUM_VCS-1:0] credit_ok   [NUM_PORTS];
  grant_t             grant       [NUM_PORTS];
  logic               buf_empty   [NUM_PORTS];

  route_table u_route_table (
    .clk         (clk),
    .reset       (reset),
    .route_cfg   (route_cfg),
    .lookup_dest (lookup_dest),
    .lookup_port (lookup_port),
    .lookup_hit  (lookup_hit)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    assign lookup_dest[p] = in_flit[p].dest;

    vc_input_buffer u_in_buf (
      .clk        (clk),
      .reset      (reset),
      .in_flit    (in_flit[p]),
      .in_write   (in_write[p]),
      .route_hit  (lookup_hit[p]),
      .route_port (lookup_port[p]),
      .dequeue    (dequeue[p]),
      .head_flit  (head_flit[p]),
      .head_valid (head_valid[p]),
      .head_route (head_route[p]),
      .credit_out (in_credit[p]),
      .empty      (buf_empty[p])
    );

    output_credit_port u_out_port (
      .clk           (clk),
      .reset         (reset),
      .grant         (grant[p]),
      .granted_flit  (head_flit[grant[p].port][grant[p].vc]),  // crossbar select
      .out_credit_in (out_credit_in[p]),
      .out_flit      (out_flit[p]),
      .out_write     (out_write[p]),
      .credit_ok     (credit_ok[p])
    );
  end

  switch_allocator u_alloc (
    .clk        (clk),
    .reset      (reset),
    .head_flit  (head_flit),
    .head_valid (head_valid),
    .head_route (head_route),
    .credit_ok  (credit_ok),
    .grant      (grant),
    .dequeue    (dequeue)
  );

  always_comb begin
    idle = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (!buf_empty[p] || grant[p].valid) begin
        idle = 1'b0;
      end
    end
  end

endmodule

// File: testbench/router_tb.sv
module router_tb
  import router_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 4;
  localparam int NUM_PKTS        = 12;  // per input channel
  localparam int MAX_LEN         = 4;
  localparam int SEND_PCT        = 70;
  localparam int RETURN_PCT      = 45;
  localparam int TOTAL_FLITS     = NUM_PORTS * NUM_VCS * NUM_PKTS * MAX_LEN;
  localparam int WATCHDOG_CYCLES = 400 + NUM_NODES + TOTAL_FLITS * 16;

  logic               clk = 1'b0;
  logic               reset;
  route_cfg_t         route_cfg;
  flit_t              in_flit       [NUM_PORTS];
  logic               in_write      [NUM_PORTS];
  logic [NUM_VCS-1:0] in_credit     [NUM_PORTS];
  flit_t              out_flit      [NUM_PORTS];
  logic               out_write     [NUM_PORTS];
  logic [NUM_VCS-1:0] out_credit_in [NUM_PORTS];
  logic               idle;

  integer seed = 32'hb0a2_44ed;
  int     error_count = 0;

  logic     tbl_valid [NUM_NODES];  // table contents as programmed
  port_id_t tbl_port  [NUM_NODES];

  // expected flits, index is port * NUM_VCS + vc
  flit_t exp_q [NUM_PORTS*NUM_VCS][$];

  int       up_credit [NUM_PORTS][NUM_VCS];
  int       pkts_left [NUM_PORTS][NUM_VCS];
  logic     in_pkt    [NUM_PORTS][NUM_VCS];
  int       pkt_len   [NUM_PORTS][NUM_VCS];
  int       pkt_pos   [NUM_PORTS][NUM_VCS];
  node_id_t pkt_dest  [NUM_PORTS][NUM_VCS];

  int       delivered [NUM_PORTS][NUM_VCS];
  int       pulses    [NUM_PORTS][NUM_VCS];
  int       ds_held   [NUM_PORTS][NUM_VCS];  // flits held downstream per output channel
  logic     worm_busy [NUM_PORTS][NUM_VCS];
  node_id_t worm_src  [NUM_PORTS][NUM_VCS];
  int       sent_ok   = 0;
  int       dropped   = 0;
  int       total_out = 0;

  router_top u_dut (
    .clk           (clk),
    .reset         (reset),
    .route_cfg     (route_cfg),
    .in_flit       (in_flit),
    .in_write      (in_write),
    .in_credit     (in_credit),
    .out_flit      (out_flit),
    .out_write     (out_write),
    .out_credit_in (out_credit_in),
    .idle          (idle)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    error_count++;
    $display("Testbench failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(string name, string got, string exp);
    $display("ERR %0d ns %s: got %s expected %s", $time, name, got, exp);
    abort_run();
  endtask

  task automatic report_failure(string what);
    $display("%0d ns: %s", $time, what);
    abort_run();
  endtask

  function automatic int rand_range(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic flit_kind_e next_kind(int pos, int len);
    if (len == 1)
      return FLIT_HEAD_TAIL;
    else if (pos == 0)
      return FLIT_HEAD;
    else if (pos == len - 1)
      return FLIT_TAIL;
    return FLIT_BODY;
  endfunction

  function automatic logic has_work(int i, int v);
    return in_pkt[i][v] || (pkts_left[i][v] > 0);
  endfunction

  function automatic logic traffic_done();
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int v = 0; v < NUM_VCS; v++) begin
        if (has_work(i, v)) begin
          return 1'b0;
        end
      end
    end
    return 1'b1;
  endfunction

  function automatic logic drained();
    for (int k = 0; k < NUM_PORTS * NUM_VCS; k++) begin
      if (exp_q[k].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic init_model();
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int v = 0; v < NUM_VCS; v++) begin
        up_credit[i][v] = BUF_DEPTH;
        pkts_left[i][v] = NUM_PKTS;
        in_pkt[i][v]    = 1'b0;
        worm_busy[i][v] = 1'b0;
        worm_src[i][v]  = '0;
      end
    end
  endtask

  task automatic check_reset_state();
    assert (idle === 1'b1) else report_mismatch("idle", $sformatf("%b", idle), "1");
    for (int p = 0; p < NUM_PORTS; p++) begin
      assert (out_write[p] === 1'b0) else
        report_mismatch($sformatf("out_write[%0d]", p), $sformatf("%b", out_write[p]), "0");
      assert (in_credit[p] === '0) else
        report_mismatch($sformatf("in_credit[%0d]", p), $sformatf("%b", in_credit[p]), "00");
    end
  endtask

  // packets of one channel must not interleave on an output channel
  task automatic check_worm(int o, flit_t f);
    int v;
    v = int'(f.vc);
    if (f.kind == FLIT_HEAD || f.kind == FLIT_HEAD_TAIL) begin
      assert (!worm_busy[o][v]) else
        report_failure($sformatf("head on output %0d vc %0d inside an open packet", o, v));
      worm_busy[o][v] = (f.kind == FLIT_HEAD);
      worm_src[o][v]  = f.src;
    end else begin
      assert (worm_busy[o][v]) else
        report_failure($sformatf("body or tail on output %0d vc %0d with no open packet", o, v));
      assert (f.src == worm_src[o][v]) else
        report_mismatch($sformatf("out_flit[%0d].src", o), $sformatf("%0d", f.src),
                        $sformatf("%0d", worm_src[o][v]));
      if (f.kind == FLIT_TAIL) begin
        worm_busy[o][v] = 1'b0;
      end
    end
  endtask

  task automatic check_outputs();
    flit_t f;
    flit_t exp;
    int    idx;
    int    src;
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int v = 0; v < NUM_VCS; v++) begin
        if (in_credit[i][v]) begin
          pulses[i][v]++;
          up_credit[i][v]++;
        end
      end
    end
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (out_write[o]) begin
        f   = out_flit[o];
        src = int'(f.src);
        assert (src < NUM_PORTS) else
          report_failure($sformatf("output %0d carried a flit from unknown source %0d", o, src));
        idx = src * NUM_VCS + int'(f.vc);
        assert (exp_q[idx].size() > 0) else
          report_failure($sformatf("output %0d carried a flit nobody sent", o));
        exp = exp_q[idx].pop_front();
        assert (f == exp) else
          report_mismatch($sformatf("out_flit[%0d]", o), $sformatf("%h", f), $sformatf("%h", exp));
        assert (tbl_valid[f.dest]) else
          report_failure($sformatf("flit to unrouted destination %0d was delivered", f.dest));
        assert (tbl_port[f.dest] == port_id_t'(o)) else
          report_mismatch($sformatf("out_write port for dest %0d", f.dest), $sformatf("%0d", o),
                          $sformatf("%0d", tbl_port[f.dest]));
        check_worm(o, f);
        delivered[src][f.vc]++;
        ds_held[o][f.vc]++;
        total_out++;
        assert (ds_held[o][f.vc] <= CREDIT_INIT) else
          report_failure($sformatf("output %0d vc %0d sent more flits than it had credits",
                                   o, f.vc));
      end
    end
    // the credit pulse is registered on the same edge as its out_write
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int v = 0; v < NUM_VCS; v++) begin
        assert (pulses[i][v] == delivered[i][v]) else
          report_mismatch($sformatf("in_credit[%0d][%0d] pulse count", i, v),
                          $sformatf("%0d", pulses[i][v]), $sformatf("%0d", delivered[i][v]));
      end
    end
  endtask

  task automatic return_credits();
    logic [NUM_VCS-1:0] ret;
    for (int o = 0; o < NUM_PORTS; o++) begin
      ret = '0;
      for (int v = 0; v < NUM_VCS; v++) begin
        if (ds_held[o][v] > 0 && rand_range(100) < RETURN_PCT) begin
          ret[v] = 1'b1;
          ds_held[o][v]--;
        end
      end
      out_credit_in[o] <= ret;
    end
  endtask

  task automatic tick();
    @(posedge clk);
    check_outputs();
    return_credits();
  endtask

  task automatic program_table();
    logic     ok;
    port_id_t p;
    for (int n = 0; n < NUM_NODES; n++) begin
      ok = (rand_range(4) != 0) && (n != NUM_NODES - 1);  // top node stays unrouted
      p  = port_id_t'(rand_range(NUM_PORTS));
      tbl_valid[n] = ok;
      tbl_port[n]  = p;
      tick();
      route_cfg <= '{wr_en: 1'b1, node: node_id_t'(n), port: p, valid: ok};
    end
    tick();
    route_cfg <= '0;
  endtask

  task automatic drive_inputs();
    int    v;
    flit_t f;
    logic  send;
    logic  routed;
    for (int i = 0; i < NUM_PORTS; i++) begin
      send = 1'b0;
      f    = '0;
      v    = rand_range(NUM_VCS);
      if (!has_work(i, v)) begin
        v = NUM_VCS - 1 - v;
      end
      if (has_work(i, v) && rand_range(100) < SEND_PCT) begin
        if (!in_pkt[i][v]) begin
          in_pkt[i][v]   = 1'b1;
          pkts_left[i][v]--;
          pkt_len[i][v]  = 1 + rand_range(MAX_LEN);
          pkt_pos[i][v]  = 0;
          pkt_dest[i][v] = node_id_t'(rand_range(NUM_NODES));
        end
        routed = tbl_valid[pkt_dest[i][v]];
        if (!routed || up_credit[i][v] > 0) begin  // dropped flits take no buffer slot
          f.kind    = next_kind(pkt_pos[i][v], pkt_len[i][v]);
          f.vc      = vc_id_t'(v);
          f.src     = node_id_t'(i);
          f.dest    = pkt_dest[i][v];
          f.payload = payload_t'($random(seed));
          send      = 1'b1;
          if (routed) begin
            up_credit[i][v]--;
            exp_q[i * NUM_VCS + v].push_back(f);
            sent_ok++;
          end else begin
            dropped++;
          end
          pkt_pos[i][v]++;
          if (pkt_pos[i][v] == pkt_len[i][v]) begin
            in_pkt[i][v] = 1'b0;
          end
        end
      end
      in_flit[i]  <= f;
      in_write[i] <= send;
    end
  endtask

  task automatic final_checks();
    assert (idle === 1'b1) else report_mismatch("idle", $sformatf("%b", idle), "1");
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int v = 0; v < NUM_VCS; v++) begin
        assert (up_credit[i][v] == BUF_DEPTH) else
          report_mismatch($sformatf("upstream credits [%0d][%0d]", i, v),
                          $sformatf("%0d", up_credit[i][v]), $sformatf("%0d", BUF_DEPTH));
      end
    end
    assert (total_out == sent_ok) else
      report_mismatch("delivered flit count", $sformatf("%0d", total_out),
                      $sformatf("%0d", sent_ok));
    assert (dropped > 0) else report_failure("no flit was sent to an unrouted destination");
  endtask

  initial begin
    reset     = 1'b1;
    route_cfg = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      in_flit[p]       = '0;
      in_write[p]      = 1'b0;
      out_credit_in[p] = '0;
    end
    init_model();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    check_reset_state();
    program_table();
    while (!traffic_done()) begin
      tick();
      drive_inputs();
    end
    tick();
    for (int p = 0; p < NUM_PORTS; p++) begin
      in_write[p] <= 1'b0;
    end
    while (!drained()) begin
      tick();
    end
    final_checks();
    if (error_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run();
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("watchdog expired before the traffic drained");
  end

endmodule

// File: vlog.f
rtl/router_pkg.sv
rtl/route_table.sv
rtl/vc_input_buffer.sv
rtl/switch_allocator.sv
rtl/output_credit_port.sv
rtl/router_top.sv
testbench/router_tb.sv

// File: Makefile
# Verilator build and run for the router testbench

VERILATOR ?= verilator
TOP       ?= router_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -j 0
PASS_MSG  ?= Testbench passed

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST) Makefile
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
